// ==== logic/video_pkg.sv ====
package video_pkg;

  // ==========================================================================
  // pixel stream types
  // ==========================================================================

  // one colour channel
  typedef logic [7:0] chan_t;

  // red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] rgb_t;

  // ==========================================================================
  // raster types
  // ==========================================================================

  // column or row position, zero based
  typedef logic [9:0] coord_t;

  // blueness grade, only 0 or 2 occur
  typedef logic [1:0] grade_t;

endpackage

// ==== logic/track_pkg.sv ====
package track_pkg;

  // ==========================================================================
  // window grid types
  // ==========================================================================

  // grade sum of one window
  typedef logic [15:0] sum_t;

  // flat window index, row * GRID_N + col
  typedef logic [5:0] win_idx_t;

  // ==========================================================================
  // tracker FSM
  // ==========================================================================

  typedef enum logic {
    ST_COLLECT,
    ST_PUBLISH
  } tracker_state_t;

endpackage

// ==== logic/raster_counter.sv ====
`timescale 1ns/1ps

module raster_counter import video_pkg::*; #(
  parameter int FRAME_W = 640,
  parameter int FRAME_H = 480
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_pixel_valid,
  output coord_t o_col,
  output coord_t o_row,
  output logic   o_frame_last
);

  coord_t col_q;
  coord_t row_q;
  logic   row_end;

  assign row_end = (col_q == coord_t'(FRAME_W - 1));

  // position of the pixel accepted at this edge
  assign o_col        = col_q;
  assign o_row        = row_q;
  assign o_frame_last = row_end && (row_q == coord_t'(FRAME_H - 1));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (i_pixel_valid) begin
      if (row_end) begin
        col_q <= '0;
        // wrap to the top after the last row
        row_q <= o_frame_last ? '0 : row_q + coord_t'(1);
      end else begin
        col_q <= col_q + coord_t'(1);
      end
    end
  end

endmodule

// ==== logic/pixel_grader.sv ====
`timescale 1ns/1ps

module pixel_grader import video_pkg::*; #(
  parameter int BLUE_THRESHOLD = 40
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_pixel_valid,
  input  rgb_t   i_rgb,
  input  coord_t i_col,
  input  coord_t i_row,
  input  logic   i_frame_last,
  output grade_t o_grade,
  output logic   o_grade_valid,
  output coord_t o_col,
  output coord_t o_row,
  output logic   o_frame_last
);

  chan_t  red, green, blue;
  chan_t  b_r, b_g, b_min;
  grade_t grade;

  assign red   = i_rgb[23:16];
  assign green = i_rgb[15:8];
  assign blue  = i_rgb[7:0];

  // saturating differences, blue must dominate both
  assign b_r   = (blue > red) ? blue - red : '0;
  assign b_g   = (blue > green) ? blue - green : '0;
  assign b_min = (b_r < b_g) ? b_r : b_g;
  assign grade = (b_min > chan_t'(BLUE_THRESHOLD)) ? grade_t'(2) : grade_t'(0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) o_grade_valid <= 1'b0;
    else          o_grade_valid <= i_pixel_valid;
  end

  // stage 1 payload, only meaningful with o_grade_valid
  always_ff @(posedge i_clk) begin
    if (i_pixel_valid) begin
      o_grade      <= grade;
      o_col        <= i_col;
      o_row        <= i_row;
      o_frame_last <= i_frame_last;
    end
  end

endmodule

// ==== logic/window_accum.sv ====
`timescale 1ns/1ps

module window_accum import video_pkg::*, track_pkg::*; #(
  parameter int WIN_SIZE = 32,
  parameter int GRID_N   = 7,
  parameter int ROW      = 0,
  parameter int COL      = 0
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_clear,
  input  coord_t i_origin_h,
  input  coord_t i_origin_v,
  input  grade_t i_grade,
  input  logic   i_grade_valid,
  input  coord_t i_col,
  input  coord_t i_row,
  output sum_t   o_sum
);

  localparam int     STEP  = WIN_SIZE / 2;
  localparam coord_t OFF_H = coord_t'(COL * STEP);
  localparam coord_t OFF_V = coord_t'(ROW * STEP);

  coord_t start_h, start_v;
  logic   in_h, in_v;

  if (ROW >= GRID_N || COL >= GRID_N) begin : g_bad_pos
    $error("window position lies outside the grid");
  end

  // square of this window, relative to the grid origin
  assign start_h = i_origin_h + OFF_H;
  assign start_v = i_origin_v + OFF_V;

  // one extra bit so the end bound cannot wrap
  assign in_h = (i_col >= start_h) &&
                ({1'b0, i_col} < ({1'b0, start_h} + 11'(WIN_SIZE)));
  assign in_v = (i_row >= start_v) &&
                ({1'b0, i_row} < ({1'b0, start_v} + 11'(WIN_SIZE)));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sum <= '0;
    end else if (i_clear) begin
      o_sum <= '0;
    end else if (i_grade_valid && in_h && in_v) begin
      o_sum <= o_sum + sum_t'(i_grade);
    end
  end

endmodule

// ==== logic/peak_tracker.sv ====
`timescale 1ns/1ps

module peak_tracker import video_pkg::*, track_pkg::*; #(
  parameter int FRAME_W  = 640,
  parameter int FRAME_H  = 480,
  parameter int WIN_SIZE = 32,
  parameter int GRID_N   = 7
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_frame_done,
  input  sum_t   i_sums [GRID_N*GRID_N],
  output logic   o_clear,
  output coord_t o_origin_h,
  output coord_t o_origin_v,
  output coord_t o_point_h,
  output coord_t o_point_v,
  output logic   o_point_valid
);

  localparam int STEP  = WIN_SIZE / 2;
  localparam int SPAN  = (GRID_N - 1) * STEP + WIN_SIZE;
  localparam int NWIN  = GRID_N * GRID_N;
  // distance from the tracked point back to the grid origin
  localparam int LEAD  = ((GRID_N - 1) / 2) * STEP + WIN_SIZE / 2;
  localparam int MAX_H = FRAME_W - SPAN;
  localparam int MAX_V = FRAME_H - SPAN;

  tracker_state_t state;
  logic           done_q;
  win_idx_t       best_idx;
  sum_t           best_sum;
  coord_t         cand_h, cand_v;

  // ==========================================================================
  // grid origin, clamped so the whole grid stays in the frame
  // ==========================================================================

  function automatic coord_t clamp_origin(coord_t pt, int max_org);
    int org;
    org = int'(pt) - LEAD;
    if (org < 0)            org = 0;
    else if (org > max_org) org = max_org;
    return coord_t'(org);
  endfunction

  assign o_origin_h = clamp_origin(o_point_h, MAX_H);
  assign o_origin_v = clamp_origin(o_point_v, MAX_V);

  // ==========================================================================
  // arg-max over the window sums
  // ==========================================================================

  always_comb begin
    best_idx = '0;
    best_sum = i_sums[0];
    // strict compare keeps the lowest index on a tie
    for (int i = 1; i < NWIN; i++) begin
      if (i_sums[i] > best_sum) begin
        best_sum = i_sums[i];
        best_idx = win_idx_t'(i);
      end
    end
  end

  // centre of the winning window
  assign cand_h = coord_t'(int'(o_origin_h) + (int'(best_idx) % GRID_N) * STEP
                           + WIN_SIZE / 2);
  assign cand_v = coord_t'(int'(o_origin_v) + (int'(best_idx) / GRID_N) * STEP
                           + WIN_SIZE / 2);

  // ==========================================================================
  // FSM
  // ==========================================================================

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state         <= ST_COLLECT;
      done_q        <= 1'b0;
      o_point_h     <= coord_t'(FRAME_W / 2);
      o_point_v     <= coord_t'(FRAME_H / 2);
      o_point_valid <= 1'b0;
      o_clear       <= 1'b0;
    end else begin
      // sums hold the last pixel once done_q is seen
      done_q        <= i_frame_done;
      o_point_valid <= 1'b0;
      o_clear       <= 1'b0;
      case (state)
        ST_COLLECT: begin
          if (done_q) state <= ST_PUBLISH;
        end
        ST_PUBLISH: begin
          o_point_valid <= 1'b1;
          o_clear       <= 1'b1;
          // no blue anywhere keeps the old point
          if (best_sum != '0) begin
            o_point_h <= cand_h;
            o_point_v <= cand_v;
          end
          state <= ST_COLLECT;
        end
        default: state <= ST_COLLECT;
      endcase
    end
  end

endmodule

// ==== logic/blob_tracker_top.sv ====
`timescale 1ns/1ps

module blob_tracker_top import video_pkg::*, track_pkg::*; #(
  parameter int FRAME_W        = 640,
  parameter int FRAME_H        = 480,
  parameter int WIN_SIZE       = 32,
  parameter int GRID_N         = 7,
  parameter int BLUE_THRESHOLD = 40
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_pixel_valid,
  input  rgb_t   i_rgb,
  output coord_t o_point_h,
  output coord_t o_point_v,
  output logic   o_point_valid
);

  // raster position of the accepted pixel
  coord_t raster_col, raster_row;
  logic   raster_last;

  // stage 1
  grade_t s1_grade;
  logic   s1_valid;
  coord_t s1_col, s1_row;
  logic   s1_last;
  logic   frame_done;

  // grid control and window results
  logic   win_clear;
  coord_t origin_h, origin_v;
  sum_t   win_sums [GRID_N*GRID_N];

  raster_counter #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) u_raster (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_pixel_valid (i_pixel_valid),
    .o_col         (raster_col),
    .o_row         (raster_row),
    .o_frame_last  (raster_last)
  );

  pixel_grader #(
    .BLUE_THRESHOLD (BLUE_THRESHOLD)
  ) u_grader (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_pixel_valid (i_pixel_valid),
    .i_rgb         (i_rgb),
    .i_col         (raster_col),
    .i_row         (raster_row),
    .i_frame_last  (raster_last),
    .o_grade       (s1_grade),
    .o_grade_valid (s1_valid),
    .o_col         (s1_col),
    .o_row         (s1_row),
    .o_frame_last  (s1_last)
  );

  assign frame_done = s1_valid && s1_last;

  // GRID_N x GRID_N overlapping windows, half a window apart
  for (genvar gr = 0; gr < GRID_N; gr++) begin : g_row
    for (genvar gc = 0; gc < GRID_N; gc++) begin : g_col
      window_accum #(
        .WIN_SIZE (WIN_SIZE),
        .GRID_N   (GRID_N),
        .ROW      (gr),
        .COL      (gc)
      ) u_win (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_clear       (win_clear),
        .i_origin_h    (origin_h),
        .i_origin_v    (origin_v),
        .i_grade       (s1_grade),
        .i_grade_valid (s1_valid),
        .i_col         (s1_col),
        .i_row         (s1_row),
        .o_sum         (win_sums[gr*GRID_N + gc])
      );
    end
  end

  peak_tracker #(
    .FRAME_W  (FRAME_W),
    .FRAME_H  (FRAME_H),
    .WIN_SIZE (WIN_SIZE),
    .GRID_N   (GRID_N)
  ) u_peak (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_frame_done  (frame_done),
    .i_sums        (win_sums),
    .o_clear       (win_clear),
    .o_origin_h    (origin_h),
    .o_origin_v    (origin_v),
    .o_point_h     (o_point_h),
    .o_point_v     (o_point_v),
    .o_point_valid (o_point_valid)
  );

endmodule

// ==== sim/blob_tracker_props.sv ====
`timescale 1ns/1ps

module blob_tracker_props import video_pkg::*; #(
  parameter int FRAME_W  = 640,
  parameter int FRAME_H  = 480,
  parameter int WIN_SIZE = 32,
  parameter int GRID_N   = 7
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_point_valid,
  input  logic   i_clear,
  input  coord_t i_origin_h,
  input  coord_t i_origin_v
);

  localparam int     SPAN  = (GRID_N - 1) * (WIN_SIZE / 2) + WIN_SIZE;
  localparam coord_t MAX_H = coord_t'(FRAME_W - SPAN);
  localparam coord_t MAX_V = coord_t'(FRAME_H - SPAN);

  // ==========================================================================
  // point publish
  // ==========================================================================

  valid_one_cycle: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_point_valid |=> !i_point_valid
  ) else $error("o_point_valid stayed high for more than one cycle");

  // accumulators restart with every published point
  clear_with_valid: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_clear == i_point_valid
  ) else $error("o_clear and o_point_valid are not asserted together");

  // ==========================================================================
  // grid origin
  // ==========================================================================

  origin_h_clamped: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_origin_h <= MAX_H
  ) else $error("grid origin h 0x%0h lies beyond 0x%0h", i_origin_h, MAX_H);

  origin_v_clamped: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_origin_v <= MAX_V
  ) else $error("grid origin v 0x%0h lies beyond 0x%0h", i_origin_v, MAX_V);

endmodule

// ==== sim/tb_blob_tracker.sv ====
`timescale 1ns/1ps

module tb_blob_tracker import video_pkg::*; ();

  localparam int FRAME_W        = 64;
  localparam int FRAME_H        = 48;
  localparam int WIN_SIZE       = 8;
  localparam int GRID_N         = 5;
  localparam int BLUE_THRESHOLD = 40;
  localparam int CLK_PERIOD     = 8;
  localparam int LATENCY        = 3;
  localparam int IDLE_CYCLES    = 6;
  localparam int MAX_WAIT       = 20;
  // idle cycles a gapped frame adds at most
  localparam int MAX_GAP        = 512;
  localparam int MAX_FRAMES     = 64;

  logic   clk;
  logic   rst_n;
  logic   pixel_valid;
  rgb_t   rgb;
  coord_t point_h;
  coord_t point_v;
  logic   point_valid;

  // one entry per frame of the data file
  int blob_x    [MAX_FRAMES];
  int blob_y    [MAX_FRAMES];
  int blob_w    [MAX_FRAMES];
  int blob_h    [MAX_FRAMES];
  int blob_kind [MAX_FRAMES];
  int gap_on    [MAX_FRAMES];
  int exp_h     [MAX_FRAMES];
  int exp_v     [MAX_FRAMES];
  int n_frames;
  bit frames_loaded;
  int errors;
  int frame_errors;

  blob_tracker_top #(
    .FRAME_W        (FRAME_W),
    .FRAME_H        (FRAME_H),
    .WIN_SIZE       (WIN_SIZE),
    .GRID_N         (GRID_N),
    .BLUE_THRESHOLD (BLUE_THRESHOLD)
  ) i_dut (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_pixel_valid (pixel_valid),
    .i_rgb         (rgb),
    .o_point_h     (point_h),
    .o_point_v     (point_v),
    .o_point_valid (point_valid)
  );

  bind peak_tracker blob_tracker_props #(
    .FRAME_W  (FRAME_W),
    .FRAME_H  (FRAME_H),
    .WIN_SIZE (WIN_SIZE),
    .GRID_N   (GRID_N)
  ) u_props (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_point_valid (o_point_valid),
    .i_clear       (o_clear),
    .i_origin_h    (o_origin_h),
    .i_origin_v    (o_origin_v)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(string name, int got, int expected);
    assert (got == expected) else begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, expected);
      frame_errors++;
    end
  endtask

  task automatic load_frames();
    int    fd;
    int    n;
    int    v [8];
    string line;
    n_frames = 0;
    fd = $fopen("sim/tracker_testdata.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open the data file sim/tracker_testdata.txt");
      errors++;
    end
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %d %d %d %d %d %d %d",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
      if (n != 8 || n_frames == MAX_FRAMES) begin
        $display("unreadable data line: %s", line);
        errors++;
        continue;
      end
      blob_x[n_frames]    = v[0];
      blob_y[n_frames]    = v[1];
      blob_w[n_frames]    = v[2];
      blob_h[n_frames]    = v[3];
      blob_kind[n_frames] = v[4];
      gap_on[n_frames]    = v[5];
      exp_h[n_frames]     = v[6];
      exp_v[n_frames]     = v[7];
      n_frames++;
    end
    $fclose(fd);
  endtask

  function automatic rgb_t pixel_colour(bit in_blob, int kind);
    chan_t red;
    chan_t green;
    chan_t blue;
    if (!in_blob) begin
      // background keeps blue below both other channels
      red   = chan_t'($urandom_range(255, 60));
      green = chan_t'($urandom_range(255, 60));
      blue  = chan_t'($urandom_range(59, 0));
    end else if (kind == 0) begin
      red   = chan_t'($urandom_range(40, 0));
      green = chan_t'($urandom_range(40, 0));
      blue  = chan_t'($urandom_range(255, 200));
    end else begin
      // smaller difference lands exactly on the threshold
      red   = chan_t'($urandom_range(100, 0));
      green = chan_t'($urandom_range(100, 0));
      blue  = ((red > green) ? red : green) + chan_t'(BLUE_THRESHOLD);
    end
    return {red, green, blue};
  endfunction

  // no point may be published mid-frame
  task automatic frame_step();
    step();
    check_value("o_point_valid", int'(point_valid), 0);
  endtask

  task automatic drive_frame(int f);
    int gap_left;
    int span;
    bit in_blob;
    gap_left = MAX_GAP;
    for (int row = 0; row < FRAME_H; row++) begin
      for (int col = 0; col < FRAME_W; col++) begin
        if (gap_on[f] != 0 && gap_left > 0 && (row + col) > 0 &&
            $urandom_range(15, 0) == 0) begin
          span = int'($urandom_range(4, 1));
          if (span > gap_left) span = gap_left;
          gap_left -= span;
          pixel_valid = 1'b0;
          repeat (span) frame_step();
        end
        in_blob = col >= blob_x[f] && col < blob_x[f] + blob_w[f] &&
                  row >= blob_y[f] && row < blob_y[f] + blob_h[f];
        pixel_valid = 1'b1;
        rgb         = pixel_colour(in_blob, blob_kind[f]);
        frame_step();
        // a difference of exactly the threshold does not count as blue
        if (in_blob && blob_kind[f] == 1) begin
          check_value("s1_grade", int'(i_dut.s1_grade), 0);
        end
      end
    end
    pixel_valid = 1'b0;
  endtask

  task automatic wait_point(output int cycles, output bit seen);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < MAX_WAIT) begin
      step();
      cycles++;
      seen = point_valid;
    end
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin : main
    int cycles;
    int passed;
    bit seen;
    pixel_valid   = 1'b0;
    rgb           = '0;
    rst_n         = 1'b0;
    errors        = 0;
    passed        = 0;
    frames_loaded = 1'b0;
    void'($urandom(85));
    load_frames();
    frames_loaded = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // tracker starts on the frame centre
    frame_errors = 0;
    check_value("o_point_h", int'(point_h), FRAME_W / 2);
    check_value("o_point_v", int'(point_v), FRAME_H / 2);
    check_value("o_point_valid", int'(point_valid), 0);
    errors += frame_errors;

    for (int f = 0; f < n_frames; f++) begin
      frame_errors = 0;
      drive_frame(f);
      wait_point(cycles, seen);
      assert (seen) else begin
        $display("no o_point_valid pulse within %0d cycles of the last pixel", MAX_WAIT);
        frame_errors++;
      end
      if (seen) begin
        assert (cycles == LATENCY) else begin
          $display("o_point_valid came %0d cycles after the last pixel, not %0d",
                   cycles, LATENCY);
          frame_errors++;
        end
        check_value("o_point_h", int'(point_h), exp_h[f]);
        check_value("o_point_v", int'(point_v), exp_v[f]);
        step();
        check_value("o_point_valid", int'(point_valid), 0);
        for (int i = cycles + 1; i < IDLE_CYCLES; i++) step();
      end
      $display("frame %0d: blob %0dx%0d at (%0d,%0d) gap %0d, point (%0d,%0d), %s",
               f, blob_w[f], blob_h[f], blob_x[f], blob_y[f], gap_on[f],
               point_h, point_v, (frame_errors == 0) ? "ok" : "FAILED");
      errors += frame_errors;
      if (frame_errors == 0) passed++;
    end

    if (n_frames == 0) begin
      $display("no frames were read from the data file");
      errors++;
    end
    $display("frames %0d, passed %0d, failed %0d, errors %0d",
             n_frames, passed, n_frames - passed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // whole run bounded by the frame count with worst case gaps
  initial begin : watchdog
    int limit_ns;
    wait (frames_loaded);
    limit_ns = (n_frames * (FRAME_W * FRAME_H + MAX_GAP + 20) + 8) * CLK_PERIOD;
    #(limit_ns);
    $display("timeout after %0d ns, the frames did not complete", limit_ns);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/video_pkg.sv
logic/track_pkg.sv
logic/raster_counter.sv
logic/pixel_grader.sv
logic/window_accum.sv
logic/peak_tracker.sv
logic/blob_tracker_top.sv
sim/blob_tracker_props.sv
sim/tb_blob_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the blob tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_blob_tracker \
  -f vlog.f

# the log holds the verdict line of the testbench
./obj_dir/Vtb_blob_tracker 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== sim/tracker_testdata.txt ====
# blob at column x, row y, w by h pixels; kind 0 strong blue, 1 blue just at the threshold
# x y w h kind gap exp_h exp_v (w of 0 gives a frame with no blob)
0 0 0 0 0 0 32 24
36 28 8 8 0 0 40 32
44 36 8 8 0 0 48 40
44 36 8 8 0 1 48 40
44 36 8 8 1 0 48 40
0 0 8 8 0 0 48 40
52 40 8 8 0 0 56 44
44 24 4 8 0 0 44 28
32 16 8 8 0 0 36 20
24 8 8 8 0 1 28 12
16 0 8 8 0 0 20 4
